// File: verilog.f
+incdir+source
source/sa_pkg.sv
source/os_pe.sv
source/pe_array.sv
source/edge_skew.sv
source/os_sequencer.sv
source/sa_top.sv
bench/sa_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module sa_tb -f verilog.f -Mdir obj_dir
	obj_dir/Vsa_tb > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: bench/sa_tb.sv
`default_nettype none

`include "sa_defs.svh"

module sa_tb
    import sa_pkg::*;
();

    localparam int HALF       = 5;
    localparam int PERIOD     = 2 * HALF;
    localparam int DW         = `SA_DATA_W;
    localparam int AW         = `SA_ACC_W;
    localparam int RW         = $clog2(`SA_N);
    localparam int JOBS_B2B   = 20;
    localparam int JOBS_GAP   = 20;
    localparam int JOBS_LAT   = 10;
    localparam int JOBS_SAT   = 3;
    localparam int JOBS_RST   = 2;
    localparam int TOTAL_JOBS = JOBS_B2B + JOBS_GAP + JOBS_LAT + JOBS_SAT + JOBS_RST + 1;
    localparam int WATCHDOG_CYCLES =
        TOTAL_JOBS * (`SA_DOT_LEN * 4 + `SA_RESULT_LAT + `SA_N) + 100;

    logic        clk;
    logic        rst;
    logic        in_valid;
    beat_t       in_beat;
    logic        out_valid;
    result_row_t out_row;

    result_row_t exp_rows [$];  // model results in output order
    time         exp_due [$];   // edge after which each row is due
    logic [31:0] rng_state;
    int          errors = 0;
    int          rows_seen = 0;
    bit          check_timing;

    sa_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic beat_t random_beat();
        beat_t b;
        for (int i = 0; i < `SA_N; i++) begin
            b.act[i] = DW'(next_rand());
            b.wgt[i] = DW'(next_rand());
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // C = A * B from one A column and one B row per beat
    task automatic push_expected(input beat_t beats [`SA_DOT_LEN], input time t_last);
        result_row_t   row;
        logic [AW-1:0] sum;
        for (int r = 0; r < `SA_N; r++) begin
            row.row = RW'(r);
            for (int c = 0; c < `SA_N; c++) begin
                sum = '0;
                for (int k = 0; k < `SA_DOT_LEN; k++) begin
                    sum = sum + AW'(beats[k].act[r]) * AW'(beats[k].wgt[c]);  // wraps
                end
                row.vals[c] = sum;
            end
            exp_rows.push_back(row);
            exp_due.push_back(t_last + time'((`SA_RESULT_LAT + r) * PERIOD));
        end
    endtask

    // only a job with all its beats goes to the model
    task automatic run_job(input int valid_pct, input bit saturate, input int n_beats);
        beat_t beats [`SA_DOT_LEN];
        beat_t beat;
        time   t_last;
        int    k;
        k = 0;
        t_last = 0;
        while (k < n_beats) begin
            @(posedge clk);
            if ((next_rand() % 100) < 32'(valid_pct)) begin
                if (saturate) begin
                    beat = '1;
                end else begin
                    beat = random_beat();
                end
                beats[k] = beat;
                in_valid <= 1'b1;
                in_beat  <= beat;
                t_last = $time;  // edge that drives this beat
                k++;
            end else begin
                in_valid <= 1'b0;
                in_beat  <= random_beat();  // junk data that the DUT ignores
            end
        end
        if (n_beats == `SA_DOT_LEN) begin
            push_expected(beats, t_last);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_rows.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int errs,
                               input int rows);
        $display("test %0d %s: %0d rows checked, %0d errors", num, name, rows, errs);
    endtask

    task automatic run_test(input int num, input string name, input int jobs,
                            input int valid_pct, input bit saturate, input bit timing);
        int err0;
        int rows0;
        err0 = errors;
        rows0 = rows_seen;
        check_timing = timing;
        for (int j = 0; j < jobs; j++) begin
            run_job(valid_pct, saturate, `SA_DOT_LEN);
        end
        wait_drain();
        check_timing = 1'b0;
        report_test(num, name, errors - err0, rows_seen - rows0);
    endtask

    task automatic run_reset_test();
        int err0;
        int rows0;
        err0 = errors;
        rows0 = rows_seen;
        run_job(100, 1'b0, 2);  // abandoned after two beats
        @(posedge clk);
        in_valid <= 1'b0;
        rst      <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        check_timing = 1'b1;
        for (int j = 0; j < JOBS_RST; j++) begin
            run_job(100, 1'b0, `SA_DOT_LEN);
        end
        wait_drain();
        check_timing = 1'b0;
        report_test(5, "reset mid-job", errors - err0, rows_seen - rows0);
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        result_row_t exp_row;
        time         due;
        if (out_valid === 1'b1) begin
            if (exp_rows.size() == 0) begin
                $display("ERROR at %0t: out_valid high while no result is pending", $time);
                errors++;
            end else begin
                exp_row = exp_rows.pop_front();
                due = exp_due.pop_front();
                check_value("out_row.row", 32'(out_row.row), 32'(exp_row.row));
                for (int c = 0; c < `SA_N; c++) begin
                    check_value($sformatf("out_row.vals[%0d]", c),
                                32'(out_row.vals[c]), 32'(exp_row.vals[c]));
                end
                if (check_timing) begin
                    check_value("out_valid edge time", 32'($time - HALF), 32'(due));
                end
                rows_seen++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles with results still pending",
                 WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rng_state    = 32'd4;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        check_timing = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        run_test(1, "back-to-back", JOBS_B2B, 100, 1'b0, 1'b0);
        run_test(2, "random gaps", JOBS_GAP, 60, 1'b0, 1'b0);
        run_test(3, "fixed latency", JOBS_LAT, 100, 1'b0, 1'b1);
        run_test(4, "saturating operands", JOBS_SAT, 100, 1'b1, 1'b0);
        run_reset_test();

        $display("summary: 5 tests, %0d rows checked, %0d errors", rows_seen, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/sa_top.sv
`default_nettype none

`include "sa_defs.svh"

module sa_top
    import sa_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        in_valid,
    input  wire beat_t       in_beat,
    output logic             out_valid,
    output result_row_t      out_row
);

    act_lane_t [`SA_N-1:0] tag_act;
    wgt_lane_t [`SA_N-1:0] tag_wgt;
    act_lane_t [`SA_N-1:0] left_in;   // staggered rows
    wgt_lane_t [`SA_N-1:0] top_in;    // staggered columns
    acc_matrix_t           acc;
    logic                  job_done;

    os_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .tag_act   (tag_act),
        .tag_wgt   (tag_wgt),
        .acc       (acc),
        .job_done  (job_done),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

    edge_skew #(.LANE_T(act_lane_t), .LANES(`SA_N)) u_skew_left (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (tag_act),
        .lanes_out (left_in)
    );

    edge_skew #(.LANE_T(wgt_lane_t), .LANES(`SA_N)) u_skew_top (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (tag_wgt),
        .lanes_out (top_in)
    );

    pe_array u_array (
        .clk      (clk),
        .rst      (rst),
        .left_in  (left_in),
        .top_in   (top_in),
        .acc      (acc),
        .job_done (job_done)
    );

endmodule

`default_nettype wire

// File: source/os_sequencer.sv
`default_nettype none

`include "sa_defs.svh"

module os_sequencer
    import sa_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire beat_t                  in_beat,
    output act_lane_t [`SA_N-1:0]       tag_act,
    output wgt_lane_t [`SA_N-1:0]       tag_wgt,
    input  wire acc_matrix_t            acc,
    input  wire logic                   job_done,
    output logic                        out_valid,
    output result_row_t                 out_row
);

    localparam int BEAT_W = (`SA_DOT_LEN > 1) ? $clog2(`SA_DOT_LEN) : 1;
    localparam int ROW_W  = $clog2(`SA_N);

    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_first;
    logic              beat_last;

    seq_state_t        state;
    logic [ROW_W-1:0]  row_cnt;
    acc_matrix_t       drain_buf;

    assign beat_first = (beat_cnt == '0);
    assign beat_last  = (beat_cnt == BEAT_W'(`SA_DOT_LEN - 1));

    // one tag register for every lane
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag_act  <= '0;
            tag_wgt  <= '0;
            beat_cnt <= '0;
        end else begin
            for (int i = 0; i < `SA_N; i++) begin
                tag_act[i].valid <= in_valid;
                tag_act[i].first <= in_valid && beat_first;
                tag_act[i].last  <= in_valid && beat_last;
                tag_act[i].data  <= in_beat.act[i];
                tag_wgt[i].valid <= in_valid;
                tag_wgt[i].data  <= in_beat.wgt[i];
            end
            if (in_valid) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;  // modulo job length
            end
        end
    end

    // snapshot of the aligned sums
    always_ff @(posedge clk) begin
        if (job_done) begin
            drain_buf <= acc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            row_cnt <= '0;
        end else if (job_done) begin
            state   <= DRAIN;
            row_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    row_cnt <= '0;
                end
                DRAIN: begin
                    if (row_cnt == ROW_W'(`SA_N - 1)) begin
                        state   <= IDLE;  // all rows out
                        row_cnt <= '0;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign out_valid    = (state == DRAIN);
    assign out_row.row  = row_cnt;
    assign out_row.vals = drain_buf[row_cnt];

    // job spacing of SA_DOT_LEN beats keeps snapshots apart
    assert property (@(posedge clk) disable iff (rst) job_done |-> state == IDLE)
        else $error("os_sequencer: job_done while rows still draining");

endmodule

`default_nettype wire

// File: source/edge_skew.sv
`default_nettype none

module edge_skew #(
    parameter type LANE_T = logic,
    parameter int  LANES  = 1
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire LANE_T [LANES-1:0] lanes_in,
    output LANE_T [LANES-1:0]      lanes_out
);

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        if (i == 0) begin : g_pass
            assign lanes_out[i] = lanes_in[i];  // lane 0 enters without delay
        end else begin : g_dly
            LANE_T pipe [i];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int k = 0; k < i; k++) begin
                        pipe[k] <= '0;  // clears valid
                    end
                end else begin
                    pipe[0] <= lanes_in[i];
                    for (int k = 1; k < i; k++) begin
                        pipe[k] <= pipe[k-1];
                    end
                end
            end

            assign lanes_out[i] = pipe[i-1];
        end
    end

endmodule

`default_nettype wire

// File: source/pe_array.sv
`default_nettype none

`include "sa_defs.svh"

module pe_array
    import sa_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire act_lane_t [`SA_N-1:0]  left_in,
    input  wire wgt_lane_t [`SA_N-1:0]  top_in,
    output acc_matrix_t                 acc,
    output logic                        job_done
);

    act_lane_t            act_h [`SA_N][`SA_N+1];  // links along each row
    wgt_lane_t            wgt_v [`SA_N+1][`SA_N];  // links down each column
    logic [`SA_ACC_W-1:0] cell_acc [`SA_N][`SA_N];

    for (genvar r = 0; r < `SA_N; r++) begin : g_row
        assign act_h[0+r][0] = left_in[r];
        assign wgt_v[0][r]   = top_in[r];

        for (genvar c = 0; c < `SA_N; c++) begin : g_col
            // cell (r,c) finishes DLY cycles ahead of the corner
            localparam int DLY = 2 * (`SA_N - 1) - r - c;

            os_pe u_pe (
                .clk     (clk),
                .rst     (rst),
                .act_in  (act_h[r][c]),
                .wgt_in  (wgt_v[r][c]),
                .act_out (act_h[r][c+1]),
                .wgt_out (wgt_v[r+1][c]),
                .acc     (cell_acc[r][c])
            );

            if (DLY == 0) begin : g_corner
                assign acc[r][c] = cell_acc[r][c];
            end else begin : g_align
                logic [`SA_ACC_W-1:0] hold [DLY];  // lines up sums with the corner

                always_ff @(posedge clk or posedge rst) begin
                    if (rst) begin
                        for (int k = 0; k < DLY; k++) begin
                            hold[k] <= '0;
                        end
                    end else begin
                        hold[0] <= cell_acc[r][c];
                        for (int k = 1; k < DLY; k++) begin
                            hold[k] <= hold[k-1];
                        end
                    end
                end

                assign acc[r][c] = hold[DLY-1];
            end
        end
    end

    // corner takes its last product on this same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_done <= 1'b0;
        end else begin
            job_done <= act_h[`SA_N-1][`SA_N-1].valid && act_h[`SA_N-1][`SA_N-1].last;
        end
    end

endmodule

`default_nettype wire

// File: source/os_pe.sv
`default_nettype none

`include "sa_defs.svh"

module os_pe
    import sa_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire act_lane_t            act_in,
    input  wire wgt_lane_t            wgt_in,
    output act_lane_t                 act_out,
    output wgt_lane_t                 wgt_out,
    output logic [`SA_ACC_W-1:0]      acc
);

    logic [2*`SA_DATA_W-1:0] prod;
    logic [`SA_ACC_W-1:0]    prod_ext;

    assign prod     = act_in.data * wgt_in.data;
    assign prod_ext = {{(`SA_ACC_W - 2*`SA_DATA_W){1'b0}}, prod};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (act_in.valid) begin
            if (act_in.first) begin
                acc <= prod_ext;  // new job overwrites old sum
            end else begin
                acc <= acc + prod_ext;  // wraps at acc width
            end
        end
    end

    // operands move one cell per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_out <= '0;
            wgt_out <= '0;
        end else begin
            act_out <= act_in;
            wgt_out <= wgt_in;
        end
    end

    // operands must arrive here as a pair
    assert property (@(posedge clk) disable iff (rst) act_in.valid == wgt_in.valid)
        else $error("os_pe: act and wgt lanes out of step");

endmodule

`default_nettype wire

// File: source/sa_pkg.sv
`default_nettype none

`include "sa_defs.svh"

package sa_pkg;

    typedef struct packed {
        logic                  valid;
        logic                  first;  // beat 0 of a job
        logic                  last;   // final beat of a job
        logic [`SA_DATA_W-1:0] data;
    } act_lane_t;

    typedef struct packed {
        logic                  valid;
        logic [`SA_DATA_W-1:0] data;
    } wgt_lane_t;

    typedef struct packed {
        logic [`SA_N-1:0][`SA_DATA_W-1:0] act;  // one column of A
        logic [`SA_N-1:0][`SA_DATA_W-1:0] wgt;  // one row of B
    } beat_t;

    typedef logic [`SA_N-1:0][`SA_N-1:0][`SA_ACC_W-1:0] acc_matrix_t;  // [row][col]

    typedef struct packed {
        logic [$clog2(`SA_N)-1:0]         row;
        logic [`SA_N-1:0][`SA_ACC_W-1:0] vals;
    } result_row_t;

    typedef enum logic {
        IDLE,   // nothing pending
        DRAIN   // emitting rows
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/sa_defs.svh
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

// N x N array of processing elements
`define SA_N          3
`define SA_DATA_W     8     // unsigned operands
`define SA_ACC_W      20    // sums wrap at this width

// beats per job must not be less than SA_N
`define SA_DOT_LEN    4

// last beat sampled to first out_valid
`define SA_RESULT_LAT (2 * `SA_N + 1)

`endif
